// ==== soc_macros.svh ====
/* Address map, widths and reset timing shared by the RTL. Windows must not overlap,
   and the map sizes are fixed here rather than reported by the slaves */
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Bus widths
`define SOC_DATA_W 32
`define SOC_ADDR_W 16
`define SOC_SEL_W 4

// Slave windows as byte addresses
`define RAM_BASE 16'h0000
`define RAM_SIZE 16'h0400
`define DEVTBL_BASE 16'h1000
`define DEVTBL_SIZE 16'h0100
`define INTC_BASE 16'h1100
`define INTC_SIZE 16'h0100

// Cycles that the internal reset is held after the pin reset or a warm reset
`define RST_STRETCH 8

// Number of interrupt source pins, at most 16
`define INT_SRC_N 4

`endif

// ==== soc_pkg.sv ====
/* Bus and reset types of the subsystem. Opcode encodings follow the pi1 bus,
   where the value 3 is reserved and never issued by the master */
`include "soc_macros.svh"

package soc_pkg;

	typedef logic [`SOC_DATA_W-1:0] data_t;
	typedef logic [`SOC_ADDR_W-1:0] addr_t;
	typedef logic [`SOC_SEL_W-1:0] sel_t;

	typedef enum logic [1:0] {
		op_none = 2'b00,
		op_write = 2'b01,
		op_read = 2'b10
	} pi_op_e;

	// Held stable by the master until a cycle with rdy high
	typedef struct packed {
		pi_op_e op;
		addr_t addr;
		data_t data;
		sel_t sel;
	} pi_req_t;

	typedef struct packed {
		logic rdy;
		data_t rdata;
	} pi_rsp_t;

	typedef enum logic [1:0] {rst_run, rst_stretch, rst_off} rst_state_e;

endpackage

// ==== reset_gen.sv ====
/* The output is registered and follows rst_p one cycle late. It stays high for RST_STRETCH
   cycles from the first cycle with rst_p low, or from the cycle after a warm reset pulse */
`timescale 1ns/1ps
`include "soc_macros.svh"

module reset_gen
	import soc_pkg::*;
(
	input logic clk_w,
	input logic rst_p,
	input logic warm_rst_i,
	input logic pwr_off_i,
	output logic sys_rst_o
);

	localparam int CNT_W = $clog2(`RST_STRETCH + 1);
	localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`RST_STRETCH - 1);

	rst_state_e state_r;
	logic [CNT_W-1:0] cnt_r;

	always_ff @(posedge clk_w) begin
		if (rst_p) begin
			state_r <= rst_stretch;
			cnt_r <= CNT_LOAD;
		end else begin
			case (state_r)
			rst_run: begin
				// Power-off wins if software sets both bits in one write
				if (pwr_off_i) begin
					state_r <= rst_off;
				end else if (warm_rst_i) begin
					state_r <= rst_stretch;
					cnt_r <= CNT_LOAD;
				end
			end
			rst_stretch: begin
				if (cnt_r == '0)
					state_r <= rst_run;
				else
					cnt_r <= cnt_r - 1'b1;
			end
			rst_off: begin
				// Only the pin reset leaves this state
				cnt_r <= CNT_LOAD;
			end
			default: state_r <= rst_stretch;
			endcase
		end
	end

	assign sys_rst_o = (state_r != rst_run);

endmodule

// ==== pi_router.sv ====
/* Purely combinational decode, so the slaves see the request in the same cycle.
   Unmapped addresses complete at once, read as zero and drop writes */
`timescale 1ns/1ps
`include "soc_macros.svh"

module pi_router
	import soc_pkg::*;
(
	input pi_req_t m_req_i,
	output pi_rsp_t m_rsp_o,

	output pi_req_t ram_req_o,
	input pi_rsp_t ram_rsp_i,

	output pi_req_t dev_req_o,
	input pi_rsp_t dev_rsp_i,

	output pi_req_t int_req_o,
	input pi_rsp_t int_rsp_i
);

	logic live;
	logic ram_hit;
	logic dev_hit;
	logic int_hit;

	function automatic logic in_win(addr_t a, addr_t base, addr_t size);
		return (a >= base) && (a < base + size);
	endfunction

	assign live = (m_req_i.op != op_none);
	assign ram_hit = live && in_win(m_req_i.addr, `RAM_BASE, `RAM_SIZE);
	assign dev_hit = live && in_win(m_req_i.addr, `DEVTBL_BASE, `DEVTBL_SIZE);
	assign int_hit = live && in_win(m_req_i.addr, `INTC_BASE, `INTC_SIZE);

	// Slaves that are not addressed keep the payload but see no operation
	always_comb begin
		ram_req_o = m_req_i;
		dev_req_o = m_req_i;
		int_req_o = m_req_i;
		if (!ram_hit)
			ram_req_o.op = op_none;
		if (!dev_hit)
			dev_req_o.op = op_none;
		if (!int_hit)
			int_req_o.op = op_none;
	end

	always_comb begin
		if (ram_hit) begin
			m_rsp_o = ram_rsp_i;
		end else if (dev_hit) begin
			m_rsp_o = dev_rsp_i;
		end else if (int_hit) begin
			m_rsp_o = int_rsp_i;
		end else begin
			// Default responder, which also drives zeros while the bus is idle
			m_rsp_o.rdy = live;
			m_rsp_o.rdata = '0;
		end
	end

endmodule

// ==== scratch_ram.sv ====
/* 256 words with byte writes and no reset of the contents. Writes finish in the first
   cycle, reads in the second, and nothing completes until a cycle after reset ends */
`timescale 1ns/1ps

module scratch_ram
	import soc_pkg::*;
(
	input logic clk_w,
	input logic rst_p,
	input pi_req_t req_i,
	output pi_rsp_t rsp_o
);

	data_t mem [0:255];
	data_t rdata_r;
	logic act_r;
	logic rd_wait_r;
	logic [7:0] idx;

	// Word index from a byte address
	assign idx = req_i.addr[9:2];

	always_ff @(posedge clk_w) begin
		if (rst_p) begin
			act_r <= 1'b0;
			rd_wait_r <= 1'b0;
		end else begin
			act_r <= 1'b1;
			// Set on the first read cycle, cleared in the cycle the read completes
			if (act_r && req_i.op == op_read)
				rd_wait_r <= !rd_wait_r;
		end
	end

	always_ff @(posedge clk_w) begin
		if (act_r && req_i.op == op_write) begin
			for (int i = 0; i < $bits(sel_t); i++) begin
				if (req_i.sel[i])
					mem[idx][i*8 +: 8] <= req_i.data[i*8 +: 8];
			end
		end
		if (req_i.op == op_read)
			rdata_r <= mem[idx];
	end

	assign rsp_o.rdy = act_r && ((req_i.op == op_write) || (req_i.op == op_read && rd_wait_r));
	assign rsp_o.rdata = rdata_r;

endmodule

// ==== dev_table.sv ====
/* Read-only map of the three slaves plus the reset control word at offset 0x40.
   Control bits are taken only when byte lane 0 is selected */
`timescale 1ns/1ps
`include "soc_macros.svh"

module dev_table
	import soc_pkg::*;
(
	input logic clk_w,
	input logic rst_p,
	input pi_req_t req_i,
	output pi_rsp_t rsp_o,
	output logic warm_rst_o,
	output logic pwr_off_o
);

	localparam data_t DEV_CNT = 32'd3;

	logic act_r;
	logic warm_rst_r;
	logic pwr_off_r;
	logic ctl_wr;
	logic [7:0] off;

	assign off = req_i.addr[7:0];
	assign ctl_wr = act_r && (req_i.op == op_write) && req_i.sel[0] && (off == 8'h40);

	always_ff @(posedge clk_w) begin
		if (rst_p) begin
			act_r <= 1'b0;
			warm_rst_r <= 1'b0;
			pwr_off_r <= 1'b0;
		end else begin
			act_r <= 1'b1;
			// Single-cycle pulses, since the master drops the request after rdy
			warm_rst_r <= ctl_wr && req_i.data[0];
			pwr_off_r <= ctl_wr && req_i.data[1];
		end
	end

	always_comb begin
		case (off)
		8'h00: rsp_o.rdata = DEV_CNT;
		8'h04: rsp_o.rdata = data_t'(`RAM_SIZE);
		8'h08: rsp_o.rdata = data_t'(`DEVTBL_SIZE);
		8'h0c: rsp_o.rdata = data_t'(`INTC_SIZE);
		8'h10: rsp_o.rdata = data_t'(`RAM_BASE);
		8'h14: rsp_o.rdata = data_t'(`DEVTBL_BASE);
		8'h18: rsp_o.rdata = data_t'(`INTC_BASE);
		default: rsp_o.rdata = '0;
		endcase
	end

	assign rsp_o.rdy = act_r && (req_i.op != op_none);
	assign warm_rst_o = warm_rst_r;
	assign pwr_off_o = pwr_off_r;

endmodule

// ==== int_ctrl.sv ====
/* Sources are level sensitive, so a pending bit sets again while its pin stays high.
   Register writes are taken only when byte lane 0 is selected */
`timescale 1ns/1ps
`include "soc_macros.svh"

module int_ctrl
	import soc_pkg::*;
(
	input logic clk_w,
	input logic rst_p,
	input pi_req_t req_i,
	output pi_rsp_t rsp_o,
	input logic [`INT_SRC_N-1:0] src_i,
	output logic irq_o
);

	logic act_r;
	logic irq_r;
	logic [`INT_SRC_N-1:0] pending_r;
	logic [`INT_SRC_N-1:0] enable_r;
	logic [`INT_SRC_N-1:0] clr;
	logic [`INT_SRC_N-1:0] hot;
	logic [3:0] best;
	logic [7:0] off;
	logic wr;

	assign off = req_i.addr[7:0];
	assign wr = act_r && (req_i.op == op_write) && req_i.sel[0];
	assign clr = (wr && off == 8'h00) ? req_i.data[`INT_SRC_N-1:0] : '0;
	assign hot = pending_r & enable_r;

	// Lowest numbered active source has the highest priority
	always_comb begin
		best = '0;
		for (int i = `INT_SRC_N - 1; i >= 0; i--) begin
			if (hot[i])
				best = 4'(i);
		end
	end

	always_ff @(posedge clk_w) begin
		if (rst_p) begin
			act_r <= 1'b0;
			irq_r <= 1'b0;
			pending_r <= '0;
			enable_r <= '0;
		end else begin
			act_r <= 1'b1;
			// A source held high wins over a clear in the same cycle
			pending_r <= (pending_r & ~clr) | src_i;
			if (wr && off == 8'h04)
				enable_r <= req_i.data[`INT_SRC_N-1:0];
			irq_r <= |hot;
		end
	end

	always_comb begin
		case (off)
		8'h00: rsp_o.rdata = data_t'(pending_r);
		8'h04: rsp_o.rdata = data_t'(enable_r);
		8'h08: rsp_o.rdata = {|hot, 27'd0, best};
		default: rsp_o.rdata = '0;
		endcase
	end

	assign rsp_o.rdy = act_r && (req_i.op != op_none);
	assign irq_o = irq_r;

endmodule

// ==== soc_top.sv ====
/* Peripheral subsystem with one bus master port. Requests complete when rdy is high,
   and no slave answers while in_reset_o is high */
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_top
	import soc_pkg::*;
(
	input logic clk_w,
	input logic rst_p,
	input pi_req_t m_req_i,
	output pi_rsp_t m_rsp_o,
	input logic [`INT_SRC_N-1:0] irq_src_i,
	output logic irq_o,
	output logic in_reset_o
);

	logic sys_rst;
	logic warm_rst;
	logic pwr_off;
	pi_req_t ram_req;
	pi_req_t dev_req;
	pi_req_t int_req;
	pi_rsp_t ram_rsp;
	pi_rsp_t dev_rsp;
	pi_rsp_t int_rsp;

	reset_gen u_reset_gen (
		.clk_w (clk_w),
		.rst_p (rst_p),
		.warm_rst_i (warm_rst),
		.pwr_off_i (pwr_off),
		.sys_rst_o (sys_rst)
	);

	pi_router u_pi_router (
		.m_req_i (m_req_i),
		.m_rsp_o (m_rsp_o),
		.ram_req_o (ram_req),
		.ram_rsp_i (ram_rsp),
		.dev_req_o (dev_req),
		.dev_rsp_i (dev_rsp),
		.int_req_o (int_req),
		.int_rsp_i (int_rsp)
	);

	scratch_ram u_scratch_ram (
		.clk_w (clk_w),
		.rst_p (sys_rst),
		.req_i (ram_req),
		.rsp_o (ram_rsp)
	);

	dev_table u_dev_table (
		.clk_w (clk_w),
		.rst_p (sys_rst),
		.req_i (dev_req),
		.rsp_o (dev_rsp),
		.warm_rst_o (warm_rst),
		.pwr_off_o (pwr_off)
	);

	int_ctrl u_int_ctrl (
		.clk_w (clk_w),
		.rst_p (sys_rst),
		.req_i (int_req),
		.rsp_o (int_rsp),
		.src_i (irq_src_i),
		.irq_o (irq_o)
	);

	assign in_reset_o = sys_rst;

endmodule

// ==== soc_tb.sv ====
/* Self-checking testbench for soc_top. The map, stretch length and source count come from
   the macros header, and the interrupt pins are driven as plain levels */
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_tb
	import soc_pkg::*;
();

	typedef struct packed {
		pi_op_e op;
		addr_t addr;
		data_t wdata;
		sel_t sel;
		data_t exp;
	} step_t;

	logic clk_w;
	logic rst_p;
	pi_req_t m_req;
	pi_rsp_t m_rsp;
	logic [`INT_SRC_N-1:0] irq_src;
	logic irq;
	logic in_reset;

	step_t steps [0:63];
	string labels [0:63];
	int seg_end [0:9];
	data_t ram_model [0:255];
	data_t rng = 32'd68;
	int step_n = 0;
	int seg_n = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int checks = 0;
	int errors = 0;
	int err_mark = 0;
	int tests = 0;
	int bad_tests = 0;
	int len;

	soc_top UUT (
		.clk_w (clk_w),
		.rst_p (rst_p),
		.m_req_i (m_req),
		.m_rsp_o (m_rsp),
		.irq_src_i (irq_src),
		.irq_o (irq),
		.in_reset_o (in_reset)
	);

	always #20 clk_w = ~clk_w;

	always @(posedge clk_w) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic data_t xorshift32(input data_t x);
		data_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic check_val(input string name, input data_t got, input data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == err_mark) begin
			$display("Test %0d, %s: ok", tests, name);
		end else begin
			bad_tests++;
			$display("Test %0d, %s: %0d errors", tests, name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	task automatic add_step(input pi_op_e op, input addr_t addr, input data_t wdata,
			input sel_t sel, input data_t exp, input string label);
		steps[step_n] = {op, addr, wdata, sel, exp};
		labels[step_n] = label;
		step_n++;
	endtask

	// The model keeps only the bytes whose select bits are set
	task automatic ram_write(input addr_t addr, input sel_t sel);
		rng = xorshift32(rng);
		for (int i = 0; i < 4; i++) begin
			if (sel[i])
				ram_model[addr[9:2]][i*8 +: 8] = rng[i*8 +: 8];
		end
		add_step(op_write, addr, rng, sel, '0, $sformatf("ram wr %h", addr));
	endtask

	task automatic ram_read(input addr_t addr);
		add_step(op_read, addr, '0, 4'hf, ram_model[addr[9:2]], $sformatf("ram rd %h", addr));
	endtask

	task automatic mark_seg();
		seg_end[seg_n] = step_n;
		seg_n++;
	endtask

	task automatic build_table();
		ram_write(16'h0000, 4'hf);
		ram_write(16'h0004, 4'hf);
		ram_write(16'h03fc, 4'hf);
		ram_write(16'h0004, 4'h5);
		ram_write(16'h03fc, 4'hc);
		ram_write(16'h0000, 4'h2);
		ram_read(16'h0000);
		ram_read(16'h0004);
		ram_read(16'h03fc);
		mark_seg();
		add_step(op_read, `DEVTBL_BASE, '0, 4'hf, 32'd3, "dev count");
		add_step(op_read, `DEVTBL_BASE + 16'h04, '0, 4'hf, 32'(`RAM_SIZE), "ram size");
		add_step(op_read, `DEVTBL_BASE + 16'h08, '0, 4'hf, 32'(`DEVTBL_SIZE), "dev size");
		add_step(op_read, `DEVTBL_BASE + 16'h0c, '0, 4'hf, 32'(`INTC_SIZE), "intc size");
		add_step(op_read, `DEVTBL_BASE + 16'h10, '0, 4'hf, 32'(`RAM_BASE), "ram base");
		add_step(op_read, `DEVTBL_BASE + 16'h14, '0, 4'hf, 32'(`DEVTBL_BASE), "dev base");
		add_step(op_read, `DEVTBL_BASE + 16'h18, '0, 4'hf, 32'(`INTC_BASE), "intc base");
		add_step(op_read, `DEVTBL_BASE + 16'h1c, '0, 4'hf, '0, "dev spare");
		add_step(op_read, `DEVTBL_BASE + 16'h40, '0, 4'hf, '0, "reset ctl");
		add_step(op_write, 16'h0800, 32'hdeadbeef, 4'hf, '0, "unmapped wr");
		add_step(op_read, 16'h0800, '0, 4'hf, '0, "unmapped rd");
		add_step(op_read, `INTC_BASE + `INTC_SIZE, '0, 4'hf, '0, "past intc");
		mark_seg();
		add_step(op_write, `INTC_BASE + 16'h04, 32'h4, 4'h1, '0, "enable src 2");
		mark_seg();
		add_step(op_read, `INTC_BASE + 16'h08, '0, 4'hf, 32'h8000_0002, "active src 2");
		add_step(op_write, `INTC_BASE + 16'h04, 32'hf, 4'h1, '0, "enable all");
		mark_seg();
		add_step(op_read, `INTC_BASE + 16'h08, '0, 4'hf, 32'h8000_0001, "active src 1");
		add_step(op_read, `INTC_BASE, '0, 4'hf, 32'he, "pending 1 to 3");
		mark_seg();
		add_step(op_write, `INTC_BASE, 32'hf, 4'h1, '0, "clear pending");
		add_step(op_read, `INTC_BASE, '0, 4'hf, '0, "pending cleared");
		add_step(op_read, `INTC_BASE + 16'h08, '0, 4'hf, '0, "none active");
		mark_seg();
		add_step(op_write, `DEVTBL_BASE + 16'h40, 32'h1, 4'h1, '0, "warm reset");
		mark_seg();
		add_step(op_read, `INTC_BASE + 16'h04, '0, 4'hf, '0, "enable after warm");
		ram_read(16'h0000);
		ram_read(16'h0004);
		ram_read(16'h03fc);
		mark_seg();
		add_step(op_write, `DEVTBL_BASE + 16'h40, 32'h2, 4'h1, '0, "power off");
		mark_seg();
		add_step(op_read, `DEVTBL_BASE, '0, 4'hf, 32'd3, "count after off");
		ram_write(16'h0008, 4'hf);
		ram_read(16'h0008);
		ram_read(16'h0004);
		mark_seg();
	endtask

	// Holds the request until rdy, then returns the bus to op none
	task automatic bus_access(input step_t s, input string label);
		pi_req_t req;
		data_t rdata;
		logic ok;
		int waited;
		req = {s.op, s.addr, s.wdata, s.sel};
		waited = 0;
		@(posedge clk_w);
		m_req <= req;
		@(negedge clk_w);
		while (!m_rsp.rdy && waited < 32) begin
			waited++;
			@(negedge clk_w);
		end
		ok = m_rsp.rdy;
		rdata = m_rsp.rdata;
		req.op = op_none;
		@(posedge clk_w);
		m_req <= req;
		if (!ok) begin
			errors++;
			$display("No ready within 32 cycles for %s at address %h", label, s.addr);
		end else if (s.op == op_read) begin
			check_val({"rdata ", label}, rdata, s.exp);
		end
	endtask

	task automatic run_seg(input int k);
		int first;
		first = (k == 0) ? 0 : seg_end[k-1];
		for (int i = first; i < seg_end[k]; i++)
			bus_access(steps[i], labels[i]);
	endtask

	task automatic wait_in_reset();
		int guard;
		guard = 0;
		@(negedge clk_w);
		while (!in_reset && guard < 16) begin
			guard++;
			@(negedge clk_w);
		end
		if (!in_reset) begin
			errors++;
			$display("in_reset_o did not rise within 16 cycles");
		end
	endtask

	// Counts the falling edges at which in_reset_o is high
	task automatic count_stretch(output int cnt);
		cnt = 0;
		wait_in_reset();
		while (in_reset && cnt < 64) begin
			cnt++;
			@(negedge clk_w);
		end
	endtask

	task automatic wait_irq(input logic level);
		int guard;
		guard = 0;
		@(negedge clk_w);
		while (irq !== level && guard < 8) begin
			guard++;
			@(negedge clk_w);
		end
		check_val("irq_o", irq, level);
	endtask

	task automatic drive_src(input logic [`INT_SRC_N-1:0] value);
		@(posedge clk_w);
		irq_src <= value;
	endtask

	initial begin
		clk_w = 1'b0;
		rst_p = 1'b1;
		m_req = '0;
		irq_src = '0;
		build_table();
		cycle_limit = step_n * 4 + 200;
		repeat (2) @(posedge clk_w);
		@(negedge clk_w);
		check_val("in_reset_o during rst_p", in_reset, 1'b1);
		@(posedge clk_w);
		rst_p <= 1'b0;
		count_stretch(len);
		check_val("in_reset_o stretch", len, `RST_STRETCH);
		finish_test("pin reset stretch");
		run_seg(0);
		finish_test("ram byte writes");
		run_seg(1);
		finish_test("device table and unmapped");
		run_seg(2);
		drive_src(4'b0100);
		wait_irq(1'b1);
		run_seg(3);
		drive_src(4'b1110);
		run_seg(4);
		drive_src(4'b0000);
		run_seg(5);
		wait_irq(1'b0);
		finish_test("interrupts");
		run_seg(6);
		count_stretch(len);
		check_val("in_reset_o warm stretch", len, `RST_STRETCH);
		run_seg(7);
		finish_test("warm reset");
		run_seg(8);
		wait_in_reset();
		len = 0;
		repeat (50) begin
			@(negedge clk_w);
			if (in_reset)
				len++;
		end
		check_val("in_reset_o held cycles", len, 50);
		@(posedge clk_w);
		rst_p <= 1'b1;
		repeat (3) @(posedge clk_w);
		rst_p <= 1'b0;
		count_stretch(len);
		check_val("in_reset_o stretch after off", len, `RST_STRETCH);
		run_seg(9);
		finish_test("power-off");
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, bad_tests, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+.
soc_pkg.sv
reset_gen.sv
pi_router.sv
scratch_ram.sv
dev_table.sv
int_ctrl.sv
soc_top.sv
soc_tb.sv

// ==== Bender.yml ====
package:
  name: soc_periph

export_include_dirs:
  - .

sources:
  - soc_pkg.sv
  - reset_gen.sv
  - pi_router.sv
  - scratch_ram.sv
  - dev_table.sv
  - int_ctrl.sv
  - soc_top.sv
  - target: test
    files:
      - soc_tb.sv
